// File: subleqCluster.f
design/subleqPkg.sv
design/coreIf.sv
design/programStore.sv
design/subleqCore.sv
design/statCollector.sv
design/subleqCluster.sv
testbench/subleqCore_sva.sv
testbench/subleqClusterTb.sv

// File: testbench/subleqClusterTb.sv
// SUBLEQ cluster testbench
`timescale 1ns/10ps
`default_nettype none

module subleqClusterTb;

  localparam int timeoutLimit = 4000;  // six tests of a few hundred cycles
  localparam int fallCycles   = 100;
  localparam int randomCycles = 200;
  localparam int dw           = subleqPkg::dataWidth;
  localparam int cw           = subleqPkg::coreSelWidth;
  localparam int aw           = subleqPkg::bankAddrWidth;

  logic               iClock;
  logic               rst;
  logic               loadEn;
  logic [cw-1:0]      loadCore;
  logic [aw-1:0]      loadAddr;
  logic [dw-1:0]      loadData;
  logic               run;
  logic [cw-1:0]      statCore;
  subleqPkg::statKind statSel;
  logic [dw-1:0]      statValue;

  integer        seed;
  int            cycleCount = 0;
  logic [dw-1:0] progWords [subleqPkg::bankWords];  // next bank to load

  // reference model of the cluster
  logic [dw-1:0] mBank [subleqPkg::numCores][subleqPkg::bankWords];
  logic [dw-1:0] mS     [subleqPkg::numCores];
  logic [dw-1:0] mD     [subleqPkg::numCores];
  logic [dw-1:0] mB     [subleqPkg::numCores];
  logic [dw-1:0] mDiff  [subleqPkg::numCores];
  logic          mLeq   [subleqPkg::numCores];
  logic [dw-1:0] mIp    [subleqPkg::numCores];
  logic [dw-1:0] mSteps [subleqPkg::numCores];
  logic [dw-1:0] mTaken [subleqPkg::numCores];
  logic [dw-1:0] mLastA [subleqPkg::numCores];
  logic [dw-1:0] mIpCopy [subleqPkg::numCores];
  logic          mRestart;
  logic [dw-1:0] mStatValue;

  subleqCluster dut0 (
    .iClock    (iClock),
    .rst       (rst),
    .loadEn    (loadEn),
    .loadCore  (loadCore),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .run       (run),
    .statCore  (statCore),
    .statSel   (statSel),
    .statValue (statValue)
  );

  initial begin
    iClock = 1'b0;
    forever #4 iClock = ~iClock;
  end

  // one model step per rising edge, all reads before writes
  task automatic stepModel();
    logic [dw-1:0] instr;
    if (rst) begin
      mStatValue = '0;
    end else begin
      case (statSel)
        subleqPkg::statSteps: mStatValue = mSteps[statCore];
        subleqPkg::statTaken: mStatValue = mTaken[statCore];
        subleqPkg::statLastA: mStatValue = mLastA[statCore];
        default:              mStatValue = mIpCopy[statCore];
      endcase
    end
    for (int c = 0; c < subleqPkg::numCores; c++) begin
      instr = mBank[c][mIp[c][aw+1:2]];  // word index from the byte address
      if (rst) begin
        mSteps[c] = '0;
        mTaken[c] = '0;
      end else begin
        if (!mRestart) mSteps[c] = mSteps[c] + 1;
        if (mLeq[c]) mTaken[c] = mTaken[c] + 1;
      end
      mLastA[c]  = mDiff[c];
      mIpCopy[c] = mIp[c];
      if (mRestart) begin
        mS[c]    = '0;
        mD[c]    = '0;
        mB[c]    = '0;
        mDiff[c] = '0;
        mLeq[c]  = 1'b0;
        mIp[c]   = '0;
      end else begin
        mIp[c]   = mLeq[c] ? mB[c] : mIp[c] + 4;  // jump is leq
        mLeq[c]  = mDiff[c][dw-1] || (mDiff[c] == '0);
        mDiff[c] = mD[c] - mS[c];
        mS[c]    = {24'b0, instr[23:16]};
        mD[c]    = {24'b0, instr[15:8]};
        mB[c]    = {24'b0, instr[7:0]};
      end
    end
    mRestart = rst ? 1'b1 : !run;
    if (loadEn) mBank[loadCore][loadAddr] = loadData;
  endtask

  always @(posedge iClock) stepModel();

  task automatic stopWithFailure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  always @(posedge iClock) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
      stopWithFailure();
    end
  end

  task automatic waitCycles(input int n);
    repeat (n) begin
      @(posedge iClock);
      #1;
    end
  endtask

  task automatic setRun(input logic level);
    run = level;
  endtask

  function automatic logic [dw-1:0] makeWord(input logic [7:0] s, input logic [7:0] d,
                                             input logic [7:0] b);
    return {8'h00, s, d, b};
  endfunction

  task automatic loadBank(input logic [cw-1:0] core);
    for (int a = 0; a < subleqPkg::bankWords; a++) begin
      loadEn   = 1'b1;
      loadCore = core;
      loadAddr = aw'(a);
      loadData = progWords[a];
      waitCycles(1);
    end
    loadEn = 1'b0;
  endtask

  task automatic readStat(input logic [cw-1:0] core, input subleqPkg::statKind kind,
                          output logic [dw-1:0] actual);
    statCore = core;
    statSel  = kind;
    waitCycles(1);  // readout is registered
    actual = statValue;
  endtask

  task automatic checkStat(input string testName, input logic [cw-1:0] core,
                           input subleqPkg::statKind kind, input logic [dw-1:0] expected,
                           input logic [dw-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s core %0d %s expected %h actual %h",
               testName, core, kind.name(), expected, actual);
      stopWithFailure();
    end
  endtask

  task automatic compareWithModel(input string testName, input logic [cw-1:0] core,
                                  input subleqPkg::statKind kind);
    logic [dw-1:0] actual;
    readStat(core, kind, actual);
    checkStat(testName, core, kind, mStatValue, actual);
  endtask

  task automatic checkAllStats(input string testName, input logic [cw-1:0] core);
    for (int k = 0; k < 4; k++) begin
      compareWithModel(testName, core, subleqPkg::statKind'(k));
    end
  endtask

  task automatic testResetIdle();
    logic [dw-1:0] actual;
    for (int c = 0; c < subleqPkg::numCores; c++) begin
      for (int k = 0; k < 4; k++) begin
        readStat(cw'(c), subleqPkg::statKind'(k), actual);
        checkStat("resetIdle", cw'(c), subleqPkg::statKind'(k), '0, actual);
      end
    end
  endtask

  // known contents everywhere, so idle cores never fetch X
  task automatic fillAllBanks();
    for (int c = 0; c < subleqPkg::numCores; c++) begin
      for (int a = 0; a < subleqPkg::bankWords; a++) begin
        progWords[a] = makeWord(8'(c * 64 + a), 8'(a * 5 + c), 8'(a * 4));
      end
      loadBank(cw'(c));
    end
  endtask

  task automatic testFallThrough();
    logic [7:0]    s;
    logic [7:0]    d;
    logic [dw-1:0] actual;
    for (int a = 0; a < subleqPkg::bankWords; a++) begin
      s = 8'($random(seed)) & 8'h3f;
      d = s + 8'd1 + (8'($random(seed)) & 8'h3f);  // always above s
      progWords[a] = makeWord(s, d, 8'(a * 4 + 8));  // target equals fall-through
    end
    loadBank(0);
    setRun(1'b1);
    waitCycles(fallCycles - 4);
    checkAllStats("fallThrough", 0);  // four more run cycles
    setRun(1'b0);
    waitCycles(3);
    readStat(0, subleqPkg::statSteps, actual);
    checkStat("fallThrough", 0, subleqPkg::statSteps, fallCycles, actual);
    compareWithModel("fallThrough", 0, subleqPkg::statTaken);
  endtask

  task automatic testZeroBranch();
    for (int a = 0; a < subleqPkg::bankWords; a++) begin
      progWords[a] = makeWord(8'h10, 8'h18, 8'(a * 4 + 8));
    end
    progWords[3] = makeWord(8'h20, 8'h20, 8'h40);  // zero result, jump three edges later
    loadBank(0);
    setRun(1'b1);
    for (int i = 0; i < 16; i++) begin
      compareWithModel("zeroBranch", 0, subleqPkg::statIp);
    end
    compareWithModel("zeroBranch", 0, subleqPkg::statTaken);
    compareWithModel("zeroBranch", 0, subleqPkg::statLastA);
    setRun(1'b0);
    waitCycles(3);
  endtask

  task automatic testNegative();
    logic [dw-1:0] actual;
    logic [dw-1:0] expected;
    for (int a = 0; a < subleqPkg::bankWords; a++) begin
      progWords[a] = makeWord(8'h90, 8'h30, 8'h10);
    end
    expected = 32'h30 - 32'h90;  // two's complement of D minus S
    loadBank(0);
    setRun(1'b1);
    waitCycles(12);
    readStat(0, subleqPkg::statLastA, actual);
    checkStat("negative", 0, subleqPkg::statLastA, expected, actual);
    checkStat("negative", 0, subleqPkg::statLastA, mStatValue, actual);
    for (int i = 0; i < 6; i++) begin
      compareWithModel("negative", 0, subleqPkg::statIp);
    end
    compareWithModel("negative", 0, subleqPkg::statTaken);
    setRun(1'b0);
    waitCycles(3);
  endtask

  task automatic testIndependent();
    for (int c = 0; c < subleqPkg::numCores; c++) begin
      for (int a = 0; a < subleqPkg::bankWords; a++) begin
        progWords[a] = $random(seed);
      end
      loadBank(cw'(c));
    end
    setRun(1'b1);
    waitCycles(randomCycles);
    for (int c = 0; c < subleqPkg::numCores; c++) begin
      checkAllStats("independent", cw'(c));
    end
    setRun(1'b0);
    waitCycles(3);
  endtask

  task automatic testStopRestart();
    logic [dw-1:0] stepsHeld;
    logic [dw-1:0] takenHeld;
    logic [dw-1:0] actual;
    for (int a = 0; a < subleqPkg::bankWords; a++) begin
      progWords[a] = $random(seed);
    end
    loadBank(0);
    setRun(1'b1);
    waitCycles(30);
    setRun(1'b0);
    waitCycles(4);
    readStat(0, subleqPkg::statSteps, actual);
    stepsHeld = mStatValue;
    checkStat("stopRestart", 0, subleqPkg::statSteps, stepsHeld, actual);
    readStat(0, subleqPkg::statTaken, actual);
    takenHeld = mStatValue;
    checkStat("stopRestart", 0, subleqPkg::statTaken, takenHeld, actual);
    waitCycles(6);
    // counters hold while the cores sit in restart
    readStat(0, subleqPkg::statSteps, actual);
    checkStat("stopRestart", 0, subleqPkg::statSteps, stepsHeld, actual);
    readStat(0, subleqPkg::statTaken, actual);
    checkStat("stopRestart", 0, subleqPkg::statTaken, takenHeld, actual);
    readStat(0, subleqPkg::statIp, actual);
    checkStat("stopRestart", 0, subleqPkg::statIp, '0, actual);
    readStat(0, subleqPkg::statLastA, actual);
    checkStat("stopRestart", 0, subleqPkg::statLastA, '0, actual);
    setRun(1'b1);
    waitCycles(20);
    checkAllStats("stopRestart", 0);
    setRun(1'b0);
    waitCycles(3);
  endtask

  initial begin
    seed       = 32'hadf;
    rst        = 1'b1;
    loadEn     = 1'b0;
    loadCore   = '0;
    loadAddr   = '0;
    loadData   = '0;
    run        = 1'b0;
    statCore   = '0;
    statSel    = subleqPkg::statSteps;
    repeat (16) @(posedge iClock);
    #1;
    rst = 1'b0;

    testResetIdle();
    fillAllBanks();
    testFallThrough();
    testZeroBranch();
    testNegative();
    testIndependent();
    testStopRestart();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/subleqCore_sva.sv
// SUBLEQ core assertions
`timescale 1ns/10ps
`default_nettype none

module subleqCore_sva (
  input wire                            iClock,
  input wire                            restart,
  input wire [subleqPkg::dataWidth-1:0] instruction,
  input wire [subleqPkg::dataWidth-1:0] ip,
  input wire [subleqPkg::dataWidth-1:0] a,
  input wire [subleqPkg::dataWidth-1:0] b,
  input wire                            jump,
  input wire [subleqPkg::dataWidth-1:0] nextIp,
  input wire [subleqPkg::dataWidth-1:0] srcVal,
  input wire [subleqPkg::dataWidth-1:0] dstVal,
  input wire [subleqPkg::dataWidth-1:0] branchVal,
  input wire [subleqPkg::dataWidth-1:0] diff,
  input wire                            leq
);

  localparam int fw = subleqPkg::fieldWidth;

  // restart clears every visible register
  assert property (@(posedge iClock)
    restart |=> (ip == '0 && a == '0 && b == '0 && !jump && nextIp == '0))
    else $error("core outputs not zero after restart");

  // fields land zero-extended (== widens the byte with zeros)
  assert property (@(posedge iClock)
    !restart |=> (srcVal == $past(instruction[2*fw +: fw])
               && dstVal == $past(instruction[fw +: fw])
               && branchVal == $past(instruction[0 +: fw])))
    else $error("field decode wrong");

  assert property (@(posedge iClock)
    !restart |=> diff == $past(dstVal) - $past(srcVal))
    else $error("difference is not D minus S");

  assert property (@(posedge iClock)
    !restart |=> leq == ($past(diff[subleqPkg::dataWidth-1]) || $past(diff) == '0))
    else $error("leq does not follow the previous difference");

  // late redirect on jump, nextIp follows leq
  assert property (@(posedge iClock)
    !restart |=> (ip == ($past(jump) ? $past(branchVal) : $past(ip) + 32'd4)
               && nextIp == ($past(leq) ? $past(branchVal) : $past(ip) + 32'd4)))
    else $error("instruction pointer update wrong");

  assert property (@(posedge iClock) !restart |=> b == $past(branchVal))
    else $error("b is not the delayed branch target");

endmodule

bind subleqCore subleqCore_sva coreChecks (
  .iClock      (iClock),
  .restart     (port.restart),
  .instruction (port.instruction),
  .ip          (port.ip),
  .a           (port.a),
  .b           (port.b),
  .jump        (port.jump),
  .nextIp      (port.nextIp),
  .srcVal      (srcVal),
  .dstVal      (dstVal),
  .branchVal   (branchVal),
  .diff        (diff),
  .leq         (leq)
);

`default_nettype wire

// File: design/subleqCluster.sv
// SUBLEQ cluster top level
`timescale 1ns/10ps
`default_nettype none

module subleqCluster (
  input  wire                                iClock,
  input  wire                                rst,
  // program loading
  input  wire                                loadEn,
  input  wire [subleqPkg::coreSelWidth-1:0]  loadCore,
  input  wire [subleqPkg::bankAddrWidth-1:0] loadAddr,
  input  wire [subleqPkg::dataWidth-1:0]     loadData,
  // run level for all cores
  input  wire                                run,
  // statistics readout
  input  wire [subleqPkg::coreSelWidth-1:0]  statCore,
  input  wire subleqPkg::statKind            statSel,
  output logic [subleqPkg::dataWidth-1:0]    statValue
);

  coreIf coreBus [subleqPkg::numCores] ();  // one bundle per core

  programStore store (
    .iClock   (iClock),
    .rst      (rst),
    .loadEn   (loadEn),
    .run      (run),
    .loadCore (loadCore),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .cores    (coreBus)
  );

  // identical cores, each on its own bundle
  for (genvar gCore = 0; gCore < subleqPkg::numCores; gCore++) begin : gCores
    subleqCore core (
      .iClock (iClock),
      .port   (coreBus[gCore])
    );
  end

  statCollector stats (
    .iClock    (iClock),
    .rst       (rst),
    .mon       (coreBus),
    .statCore  (statCore),
    .statSel   (statSel),
    .statValue (statValue)
  );

endmodule

`default_nettype wire

// File: design/statCollector.sv
// Per-core statistics
`timescale 1ns/10ps
`default_nettype none

module statCollector (
  input  wire                                iClock,
  input  wire                                rst,
  coreIf.monitor                             mon [subleqPkg::numCores],
  input  wire [subleqPkg::coreSelWidth-1:0]  statCore,
  input  wire subleqPkg::statKind            statSel,
  output logic [subleqPkg::dataWidth-1:0]    statValue
);

  // flattened view of the monitored cores
  logic                            coreRestart [subleqPkg::numCores];
  logic                            coreJump    [subleqPkg::numCores];
  logic [subleqPkg::dataWidth-1:0] coreA       [subleqPkg::numCores];
  logic [subleqPkg::dataWidth-1:0] coreIp      [subleqPkg::numCores];

  // statistics per core
  logic [subleqPkg::dataWidth-1:0] steps [subleqPkg::numCores];
  logic [subleqPkg::dataWidth-1:0] taken [subleqPkg::numCores];
  logic [subleqPkg::dataWidth-1:0] lastA [subleqPkg::numCores];
  logic [subleqPkg::dataWidth-1:0] ipCopy [subleqPkg::numCores];

  for (genvar gCore = 0; gCore < subleqPkg::numCores; gCore++) begin : gTap
    assign coreRestart[gCore] = mon[gCore].restart;
    assign coreJump[gCore]    = mon[gCore].jump;
    assign coreA[gCore]       = mon[gCore].a;
    assign coreIp[gCore]      = mon[gCore].ip;
  end

  // counters survive run going low, only rst clears them
  always_ff @(posedge iClock) begin
    if (rst) begin
      for (int i = 0; i < subleqPkg::numCores; i++) begin
        steps[i] <= '0;
        taken[i] <= '0;
      end
    end else begin
      for (int i = 0; i < subleqPkg::numCores; i++) begin
        if (!coreRestart[i]) begin
          steps[i] <= steps[i] + 1'b1;
        end
        if (coreJump[i]) begin
          taken[i] <= taken[i] + 1'b1;
        end
      end
    end
  end

  // copies one cycle behind the cores
  always_ff @(posedge iClock) begin
    for (int i = 0; i < subleqPkg::numCores; i++) begin
      lastA[i]  <= coreA[i];
      ipCopy[i] <= coreIp[i];
    end
  end

  // registered readout, one edge after the select
  always_ff @(posedge iClock) begin
    if (rst) begin
      statValue <= '0;
    end else begin
      case (statSel)
        subleqPkg::statSteps: statValue <= steps[statCore];
        subleqPkg::statTaken: statValue <= taken[statCore];
        subleqPkg::statLastA: statValue <= lastA[statCore];
        subleqPkg::statIp:    statValue <= ipCopy[statCore];
        default:              statValue <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/subleqCore.sv
// SUBLEQ core
`timescale 1ns/10ps
`default_nettype none

module subleqCore (
  input  wire  iClock,
  coreIf.core  port
);

  // decoded operands, zero-extended
  logic [subleqPkg::dataWidth-1:0] srcVal;
  logic [subleqPkg::dataWidth-1:0] dstVal;
  logic [subleqPkg::dataWidth-1:0] branchVal;

  logic [subleqPkg::dataWidth-1:0] diff;  // D minus S, one stage after decode
  logic                            leq;   // diff was zero or negative

  logic [subleqPkg::dataWidth-1:0] ipPlus4;

  function automatic logic [subleqPkg::dataWidth-1:0] zeroExt(
    input logic [subleqPkg::fieldWidth-1:0] field
  );
    return {{(subleqPkg::dataWidth - subleqPkg::fieldWidth){1'b0}}, field};
  endfunction

  assign ipPlus4 = port.ip + 32'd4;

  always_ff @(posedge iClock) begin
    if (port.restart) begin
      srcVal      <= '0;
      dstVal      <= '0;
      branchVal   <= '0;
      diff        <= '0;
      leq         <= 1'b0;
      port.ip     <= '0;
      port.nextIp <= '0;
      port.b      <= '0;
    end else begin
      // field decode from the word at the current ip
      srcVal    <= zeroExt(port.instruction[2*subleqPkg::fieldWidth +: subleqPkg::fieldWidth]);
      dstVal    <= zeroExt(port.instruction[subleqPkg::fieldWidth +: subleqPkg::fieldWidth]);
      branchVal <= zeroExt(port.instruction[0 +: subleqPkg::fieldWidth]);

      diff <= dstVal - srcVal;
      leq  <= diff[subleqPkg::dataWidth-1] || (diff == '0);

      // fetch keeps going, a taken branch lands late
      port.ip     <= port.jump ? branchVal : ipPlus4;
      port.nextIp <= leq ? branchVal : ipPlus4;
      port.b      <= branchVal;
    end
  end

  // a and jump are plain views of the pipeline registers
  assign port.a    = diff;
  assign port.jump = leq;

endmodule

`default_nettype wire

// File: design/programStore.sv
// Per-core program banks
`timescale 1ns/10ps
`default_nettype none

module programStore (
  input  wire                                   iClock,
  input  wire                                   rst,
  input  wire                                   loadEn,
  input  wire                                   run,
  input  wire [subleqPkg::coreSelWidth-1:0]     loadCore,
  input  wire [subleqPkg::bankAddrWidth-1:0]    loadAddr,
  input  wire [subleqPkg::dataWidth-1:0]        loadData,
  coreIf.store                                  cores [subleqPkg::numCores]
);

  // one bank of words for each core
  logic [subleqPkg::dataWidth-1:0] bank [subleqPkg::numCores][subleqPkg::bankWords];

  logic restartReg;  // shared by every core

  // write port, one word per cycle
  always_ff @(posedge iClock) begin
    if (loadEn) begin
      bank[loadCore][loadAddr] <= loadData;
    end
  end

  // cores sit in restart during reset and whenever run is low
  always_ff @(posedge iClock) begin
    if (rst) begin
      restartReg <= 1'b1;
    end else begin
      restartReg <= !run;
    end
  end

  // each core reads its own bank, byte address to word index
  for (genvar gCore = 0; gCore < subleqPkg::numCores; gCore++) begin : gBank
    logic [subleqPkg::bankAddrWidth-1:0] wordAddr;

    assign wordAddr                  = cores[gCore].ip[subleqPkg::bankAddrWidth+1:2];
    assign cores[gCore].instruction  = bank[gCore][wordAddr];  // async read
    assign cores[gCore].restart      = restartReg;
  end

endmodule

`default_nettype wire

// File: design/coreIf.sv
// Core connection bundle
`timescale 1ns/10ps
`default_nettype none

interface coreIf;

  logic [subleqPkg::dataWidth-1:0] instruction;  // word at ip, from the store
  logic                            restart;      // holds the core at zero
  logic [subleqPkg::dataWidth-1:0] ip;
  logic [subleqPkg::dataWidth-1:0] a;            // subtract result
  logic [subleqPkg::dataWidth-1:0] b;            // delayed branch target
  logic                            jump;
  logic [subleqPkg::dataWidth-1:0] nextIp;

  modport store (
    output instruction, restart,
    input  ip
  );

  modport core (
    input  instruction, restart,
    output ip, a, b, jump, nextIp
  );

  // statistics side only needs these four
  modport monitor (
    input restart, ip, a, jump
  );

endinterface

`default_nettype wire

// File: design/subleqPkg.sv
// SUBLEQ cluster definitions
`default_nettype none

package subleqPkg;

  // cluster geometry
  localparam int numCores      = 4;
  localparam int coreSelWidth  = 2;
  localparam int bankWords     = 64;
  localparam int bankAddrWidth = 6;

  // datapath and instruction fields
  localparam int dataWidth  = 32;
  localparam int fieldWidth = 8;  // S, D and B are one byte each

  // readout select for the statistics port
  typedef enum logic [1:0] {
    statSteps = 2'd0,  // cycles run
    statTaken = 2'd1,  // cycles with jump high
    statLastA = 2'd2,  // latest subtract result
    statIp    = 2'd3   // latest instruction pointer
  } statKind;

endpackage

`default_nettype wire
